//--- hdl/rv32i_isa_pkg.sv
// Opcodes, ALU operations and instruction formats of RV32I, imported by the core and the testbench
`default_nettype none

package rv32i_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  typedef enum logic [6:0] {
    OP_R       = 7'b0110011,
    OP_I_ARITH = 7'b0010011,
    OP_LOAD    = 7'b0000011,
    OP_JALR    = 7'b1100111,
    OP_STORE   = 7'b0100011,
    OP_BRANCH  = 7'b1100011,
    OP_LUI     = 7'b0110111,
    OP_JAL     = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL
  } alu_op_e;

  // Only the branch conditions this core implements
  typedef enum logic [2:0] {
    F3_BEQ  = 3'b000,
    F3_BNE  = 3'b001,
    F3_BLT  = 3'b100,
    F3_BGEU = 3'b111
  } branch_f3_e;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_e    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_addr_t   rd;
    opcode_e     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_addr_t  rd;
    opcode_e    opcode;
  } j_fmt_t;

  // Same 32-bit word seen through each encoding format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

endpackage

`default_nettype wire

//--- hdl/pipe_pkg.sv
// Control bundle, ALU flags, forwarding selects and stage registers shared by the core's modules
`default_nettype none

package pipe_pkg;

  typedef struct packed {
    logic lui;
    logic alusrc;    // Immediate as second ALU operand
    logic branch;
    logic memwrite;
    logic jal;
    logic jalr;
    logic memtoreg;  // Also marks a load for the hazard check
    logic regwrite;
  } ctrl_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;  // Set when a - b does not borrow
    logic v;
  } alu_flags_t;

  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_FROM_MEM,
    FWD_FROM_WB
  } fwd_sel_e;

  typedef struct packed {
    rv32i_isa_pkg::word_t     pc;
    rv32i_isa_pkg::reg_addr_t rd;
    rv32i_isa_pkg::reg_addr_t rs1;
    rv32i_isa_pkg::reg_addr_t rs2;
    rv32i_isa_pkg::word_t     rs1_data;
    rv32i_isa_pkg::word_t     rs2_data;
    rv32i_isa_pkg::word_t     imm;     // Already picked by format in decode
    logic [2:0]               funct3;
    rv32i_isa_pkg::alu_op_e   alu_op;
    ctrl_t                    ctrl;
  } id_ex_t;

  typedef struct packed {
    rv32i_isa_pkg::word_t     pc;
    rv32i_isa_pkg::reg_addr_t rd;
    rv32i_isa_pkg::word_t     alu_result;
    rv32i_isa_pkg::word_t     store_data;
    ctrl_t                    ctrl;
  } ex_mem_t;

  typedef struct packed {
    rv32i_isa_pkg::word_t     pc;
    rv32i_isa_pkg::reg_addr_t rd;
    rv32i_isa_pkg::word_t     alu_result;
    rv32i_isa_pkg::word_t     load_data;
    ctrl_t                    ctrl;
  } mem_wb_t;

endpackage

`default_nettype wire

//--- hdl/control_decoder.sv
// Decode-stage instruction decoder producing the control bundle and ALU operation
`timescale 1ns/1ps
`default_nettype none

module control_decoder (
  input  rv32i_isa_pkg::inst_u   i_inst,
  output pipe_pkg::ctrl_t        o_ctrl,
  output rv32i_isa_pkg::alu_op_e o_alu_op
);

  import rv32i_isa_pkg::*;

  // Main decode
  always_comb
  begin
    o_ctrl = '0;  // Unknown opcodes stay all zero
    case (i_inst.r.opcode)
      OP_R:
        o_ctrl.regwrite = 1'b1;
      OP_I_ARITH:
      begin
        o_ctrl.alusrc   = 1'b1;
        o_ctrl.regwrite = 1'b1;
      end
      OP_LOAD:
      begin
        o_ctrl.alusrc   = 1'b1;
        o_ctrl.memtoreg = 1'b1;
        o_ctrl.regwrite = 1'b1;
      end
      OP_JALR:
      begin
        o_ctrl.alusrc   = 1'b1;  // Target is rs1 + imm from the ALU
        o_ctrl.jalr     = 1'b1;
        o_ctrl.regwrite = 1'b1;
      end
      OP_STORE:
      begin
        o_ctrl.alusrc   = 1'b1;
        o_ctrl.memwrite = 1'b1;
      end
      OP_BRANCH:
        o_ctrl.branch = 1'b1;
      OP_LUI:
      begin
        o_ctrl.lui      = 1'b1;
        o_ctrl.alusrc   = 1'b1;
        o_ctrl.regwrite = 1'b1;
      end
      OP_JAL:
      begin
        o_ctrl.jal      = 1'b1;
        o_ctrl.regwrite = 1'b1;
      end
      default: ;
    endcase
  end

  // ALU decode
  always_comb
  begin
    o_alu_op = ALU_ADD;  // Address and lui paths
    case (i_inst.r.opcode)
      OP_R:
        case ({i_inst.r.funct7, i_inst.r.funct3})
          10'b0100000_000: o_alu_op = ALU_SUB;
          10'b0000000_111: o_alu_op = ALU_AND;
          10'b0000000_110: o_alu_op = ALU_OR;
          10'b0000000_100: o_alu_op = ALU_XOR;
          10'b0000000_001: o_alu_op = ALU_SLL;
          default:         o_alu_op = ALU_ADD;
        endcase
      OP_I_ARITH:
        case (i_inst.i.funct3)
          3'b111:  o_alu_op = ALU_AND;
          3'b110:  o_alu_op = ALU_OR;
          3'b100:  o_alu_op = ALU_XOR;
          3'b001:  o_alu_op = ALU_SLL;  // slli
          default: o_alu_op = ALU_ADD;
        endcase
      OP_BRANCH:
        o_alu_op = ALU_SUB;  // Compare through the flags
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/regfile.sv
// Integer register file with two read ports and write-through for the decode stage
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     i_we,
  input  rv32i_isa_pkg::reg_addr_t i_rs1,
  input  rv32i_isa_pkg::reg_addr_t i_rs2,
  input  rv32i_isa_pkg::reg_addr_t i_rd,
  input  rv32i_isa_pkg::word_t     i_rd_data,
  output rv32i_isa_pkg::word_t     o_rs1_data,
  output rv32i_isa_pkg::word_t     o_rs2_data
);

  import rv32i_isa_pkg::*;

  word_t regs [1:31];  // x0 has no storage

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int idx = 1; idx < 32; idx++)
        regs[idx] <= '0;
    end
    else if (i_we && (i_rd != '0))
      regs[i_rd] <= i_rd_data;
  end

  // A register written this cycle reads back as its new value
  function automatic word_t read_port(input reg_addr_t addr);
    if (addr == '0)
      return '0;
    else if (i_we && (i_rd == addr))
      return i_rd_data;
    else
      return regs[addr];
  endfunction

  always_comb
  begin
    o_rs1_data = read_port(i_rs1);
    o_rs2_data = read_port(i_rs2);
  end

endmodule

`default_nettype wire

//--- hdl/alu.sv
// Execute-stage ALU computing the result and the compare flags
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  rv32i_isa_pkg::word_t    i_a,
  input  rv32i_isa_pkg::word_t    i_b,
  input  rv32i_isa_pkg::alu_op_e  i_op,
  output rv32i_isa_pkg::word_t    o_result,
  output pipe_pkg::alu_flags_t    o_flags
);

  import rv32i_isa_pkg::*;

  logic [32:0] diff;  // Bit 32 is the carry out of a + ~b + 1

  assign diff = {1'b0, i_a} + {1'b0, ~i_b} + 33'd1;

  always_comb
  begin
    case (i_op)
      ALU_SUB: o_result = diff[31:0];
      ALU_AND: o_result = i_a & i_b;
      ALU_OR:  o_result = i_a | i_b;
      ALU_XOR: o_result = i_a ^ i_b;
      ALU_SLL: o_result = i_a << i_b[4:0];
      default: o_result = i_a + i_b;
    endcase
  end

  // Flags always describe a - b
  assign o_flags.n = diff[31];
  assign o_flags.z = (diff[31:0] == '0);
  assign o_flags.c = diff[32];
  assign o_flags.v = (i_a[31] ^ i_b[31]) & (diff[31] ^ i_a[31]);  // Signs differ and result flipped

endmodule

`default_nettype wire

//--- hdl/hazard_unit.sv
// Hazard unit of the core that gives the load-use stall, the flush and the forwarding selects
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  input  rv32i_isa_pkg::reg_addr_t i_id_rs1,
  input  rv32i_isa_pkg::reg_addr_t i_id_rs2,
  input  pipe_pkg::id_ex_t         i_id_ex,
  input  pipe_pkg::ex_mem_t        i_ex_mem,
  input  pipe_pkg::mem_wb_t        i_mem_wb,
  input  logic                     i_redirect,
  output logic                     o_stall,
  output logic                     o_flush,
  output pipe_pkg::fwd_sel_e       o_fwd_a,
  output pipe_pkg::fwd_sel_e       o_fwd_b
);

  import rv32i_isa_pkg::*;
  import pipe_pkg::*;

  logic id_ex_load;

  assign id_ex_load = i_id_ex.ctrl.memtoreg && (i_id_ex.rd != '0);

  // Load in execute feeding the instruction in decode
  assign o_stall = id_ex_load && ((i_id_ex.rd == i_id_rs1) || (i_id_ex.rd == i_id_rs2));

  assign o_flush = i_redirect;  // Branch or jump resolved in execute

  // Younger result in memory wins over writeback
  function automatic fwd_sel_e fwd_select(
    input reg_addr_t src,
    input ex_mem_t   ex_mem,
    input mem_wb_t   mem_wb
  );
    if (ex_mem.ctrl.regwrite && (ex_mem.rd != '0) && (ex_mem.rd == src))
      return FWD_FROM_MEM;
    else if (mem_wb.ctrl.regwrite && (mem_wb.rd != '0) && (mem_wb.rd == src))
      return FWD_FROM_WB;
    else
      return FWD_NONE;
  endfunction

  always_comb
  begin
    o_fwd_a = fwd_select(i_id_ex.rs1, i_ex_mem, i_mem_wb);
    o_fwd_b = fwd_select(i_id_ex.rs2, i_ex_mem, i_mem_wb);
  end

endmodule

`default_nettype wire

//--- hdl/rv32i_cpu.sv
// Top level of the five-stage RV32I core; connect instruction ROM and data memory to its ports
`timescale 1ns/1ps
`default_nettype none

module rv32i_cpu #(
  parameter rv32i_isa_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic                 clk,
  input  logic                 reset,
  input  rv32i_isa_pkg::word_t i_inst,
  input  rv32i_isa_pkg::word_t i_mem_rdata,
  output rv32i_isa_pkg::word_t o_pc,
  output rv32i_isa_pkg::word_t o_mem_addr,
  output rv32i_isa_pkg::word_t o_mem_wdata,
  output logic                 o_mem_write
);

  import rv32i_isa_pkg::*;
  import pipe_pkg::*;

  word_t      pc;
  inst_u      if_id_inst;
  word_t      if_id_pc;
  ctrl_t      dec_ctrl;
  alu_op_e    dec_alu_op;
  word_t      dec_imm;
  word_t      rs1_data;
  word_t      rs2_data;
  id_ex_t     id_ex;
  id_ex_t     id_ex_next;
  ex_mem_t    ex_mem;
  ex_mem_t    ex_mem_next;
  mem_wb_t    mem_wb;
  mem_wb_t    mem_wb_next;
  logic       stall;
  logic       flush;
  fwd_sel_e   fwd_a;
  fwd_sel_e   fwd_b;
  word_t      fwd_a_data;
  word_t      fwd_b_data;
  word_t      alu_a;
  word_t      alu_b;
  word_t      alu_result;
  alu_flags_t alu_flags;
  logic       branch_cond;
  logic       redirect;
  word_t      redirect_target;
  word_t      wb_data;

  assign o_pc = pc;

  // Fetch
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pc <= RESET_PC;
    else if (flush)
      pc <= redirect_target;
    else if (!stall)
      pc <= pc + 32'd4;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      if_id_inst <= '0;
      if_id_pc   <= '0;
    end
    else if (flush)
      if_id_inst <= '0;  // Opcode zero decodes to an empty ctrl
    else if (!stall)
    begin
      if_id_inst <= i_inst;
      if_id_pc   <= pc;
    end
  end

  // Decode
  control_decoder u_control_decoder (
    .i_inst   (if_id_inst),
    .o_ctrl   (dec_ctrl),
    .o_alu_op (dec_alu_op)
  );

  regfile u_regfile (
    .clk        (clk),
    .reset      (reset),
    .i_we       (mem_wb.ctrl.regwrite),
    .i_rs1      (if_id_inst.r.rs1),
    .i_rs2      (if_id_inst.r.rs2),
    .i_rd       (mem_wb.rd),
    .i_rd_data  (wb_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  // Immediate by encoding format
  always_comb
  begin
    case (if_id_inst.r.opcode)
      OP_I_ARITH, OP_LOAD, OP_JALR:
        dec_imm = {{20{if_id_inst.i.imm_11_0[11]}}, if_id_inst.i.imm_11_0};
      OP_STORE:
        dec_imm = {{20{if_id_inst.s.imm_11_5[6]}}, if_id_inst.s.imm_11_5, if_id_inst.s.imm_4_0};
      OP_BRANCH:
        dec_imm = {{19{if_id_inst.b.imm_12}}, if_id_inst.b.imm_12, if_id_inst.b.imm_11,
                   if_id_inst.b.imm_10_5, if_id_inst.b.imm_4_1, 1'b0};
      OP_LUI:
        dec_imm = {if_id_inst.u.imm_31_12, 12'b0};
      OP_JAL:
        dec_imm = {{11{if_id_inst.j.imm_20}}, if_id_inst.j.imm_20, if_id_inst.j.imm_19_12,
                   if_id_inst.j.imm_11, if_id_inst.j.imm_10_1, 1'b0};
      default:
        dec_imm = '0;
    endcase
  end

  always_comb
  begin
    id_ex_next.pc       = if_id_pc;
    id_ex_next.rd       = if_id_inst.r.rd;
    id_ex_next.rs1      = if_id_inst.r.rs1;
    id_ex_next.rs2      = if_id_inst.r.rs2;
    id_ex_next.rs1_data = rs1_data;
    id_ex_next.rs2_data = rs2_data;
    id_ex_next.imm      = dec_imm;
    id_ex_next.funct3   = if_id_inst.r.funct3;
    id_ex_next.alu_op   = dec_alu_op;
    id_ex_next.ctrl     = (stall || flush) ? '0 : dec_ctrl;  // Bubble
  end

  hazard_unit u_hazard_unit (
    .i_id_rs1   (if_id_inst.r.rs1),
    .i_id_rs2   (if_id_inst.r.rs2),
    .i_id_ex    (id_ex),
    .i_ex_mem   (ex_mem),
    .i_mem_wb   (mem_wb),
    .i_redirect (redirect),
    .o_stall    (stall),
    .o_flush    (flush),
    .o_fwd_a    (fwd_a),
    .o_fwd_b    (fwd_b)
  );

  // Execute
  function automatic word_t fwd_mux(
    input fwd_sel_e sel,
    input word_t    mem_data,
    input word_t    wb_val,
    input word_t    reg_data
  );
    case (sel)
      FWD_FROM_MEM: return mem_data;
      FWD_FROM_WB:  return wb_val;
      default:      return reg_data;
    endcase
  endfunction

  always_comb
  begin
    fwd_a_data = fwd_mux(fwd_a, ex_mem.alu_result, wb_data, id_ex.rs1_data);
    fwd_b_data = fwd_mux(fwd_b, ex_mem.alu_result, wb_data, id_ex.rs2_data);
  end

  assign alu_a = id_ex.ctrl.lui ? '0 : fwd_a_data;
  assign alu_b = id_ex.ctrl.alusrc ? id_ex.imm : fwd_b_data;

  alu u_alu (
    .i_a      (alu_a),
    .i_b      (alu_b),
    .i_op     (id_ex.alu_op),
    .o_result (alu_result),
    .o_flags  (alu_flags)
  );

  always_comb
  begin
    case (id_ex.funct3)
      F3_BEQ:  branch_cond = alu_flags.z;
      F3_BNE:  branch_cond = !alu_flags.z;
      F3_BLT:  branch_cond = alu_flags.n ^ alu_flags.v;
      F3_BGEU: branch_cond = alu_flags.c;
      default: branch_cond = 1'b0;
    endcase
  end

  assign redirect = (id_ex.ctrl.branch && branch_cond) || id_ex.ctrl.jal || id_ex.ctrl.jalr;
  assign redirect_target = id_ex.ctrl.jalr ? {alu_result[31:1], 1'b0} : id_ex.pc + id_ex.imm;

  always_comb
  begin
    ex_mem_next.pc         = id_ex.pc;
    ex_mem_next.rd         = id_ex.rd;
    ex_mem_next.alu_result = alu_result;
    ex_mem_next.store_data = fwd_b_data;
    ex_mem_next.ctrl       = id_ex.ctrl;
  end

  // Memory
  assign o_mem_addr  = ex_mem.alu_result;
  assign o_mem_wdata = ex_mem.store_data;
  assign o_mem_write = ex_mem.ctrl.memwrite;

  always_comb
  begin
    mem_wb_next.pc         = ex_mem.pc;
    mem_wb_next.rd         = ex_mem.rd;
    mem_wb_next.alu_result = ex_mem.alu_result;
    mem_wb_next.load_data  = i_mem_rdata;
    mem_wb_next.ctrl       = ex_mem.ctrl;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      id_ex  <= '0;
      ex_mem <= '0;
      mem_wb <= '0;
    end
    else
    begin
      id_ex  <= id_ex_next;
      ex_mem <= ex_mem_next;
      mem_wb <= mem_wb_next;
    end
  end

  // Writeback
  always_comb
  begin
    if (mem_wb.ctrl.jal || mem_wb.ctrl.jalr)
      wb_data = mem_wb.pc + 32'd4;  // Link address
    else if (mem_wb.ctrl.memtoreg)
      wb_data = mem_wb.load_data;
    else
      wb_data = mem_wb.alu_result;
  end

endmodule

`default_nettype wire

//--- verif/tb_rv32i_cpu.sv
// Testbench for the RV32I core that builds a program in ROM, runs a reference model and checks stores
`timescale 1ns/1ps
`default_nettype none

module tb_rv32i_cpu;

  import rv32i_isa_pkg::*;

  localparam word_t RESET_PC  = 32'h0000_0200;
  localparam word_t DONE_ADDR = 32'h0000_07fc;
  localparam word_t LINK_ADDR = 32'h0000_01c0;  // Store of the jal link value
  localparam int    TIMEOUT   = 200;
  localparam int    ROM_WORDS = 128;

  logic  clk;
  logic  reset;
  word_t i_inst;
  word_t i_mem_rdata;
  word_t o_pc;
  word_t o_mem_addr;
  word_t o_mem_wdata;
  logic  o_mem_write;

  word_t       rom [0:ROM_WORDS-1];
  word_t       dmem [0:511];
  int          prog_len;
  logic [31:0] lfsr_state;
  word_t       exp_addr [$];
  word_t       exp_data [$];
  word_t       jalr_target;

  rv32i_cpu #(.RESET_PC(RESET_PC)) u_rv32i_cpu (
    .clk         (clk),
    .reset       (reset),
    .i_inst      (i_inst),
    .i_mem_rdata (i_mem_rdata),
    .o_pc        (o_pc),
    .o_mem_addr  (o_mem_addr),
    .o_mem_wdata (o_mem_wdata),
    .o_mem_write (o_mem_write)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  function automatic word_t fetch(input word_t pc);
    word_t idx;
    idx = (pc - RESET_PC) >> 2;
    if (idx < ROM_WORDS)
      return rom[idx];
    else
      return 32'h0000_0013;  // nop outside the program
  endfunction

  assign i_inst      = fetch(o_pc);
  assign i_mem_rdata = dmem[o_mem_addr[10:2]];

  always @(posedge clk)
  begin
    if (o_mem_write)
      dmem[o_mem_addr[10:2]] <= o_mem_wdata;
  end

  // Initial memory word as a hash of its byte address
  function automatic word_t fill_word(input int idx);
    word_t addr;
    addr = idx * 4;
    return (addr * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
  endfunction

  // Fibonacci LFSR with taps 32 22 2 1, stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3,
                                  input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                  input logic [2:0] f3, input logic [4:0] rd,
                                  input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_sw(input logic [11:0] imm, input logic [4:0] rs2,
                                   input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t enc_jal(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic void emit(input word_t w);
    rom[prog_len] = w;
    prog_len++;
  endfunction

  // Branch over two wrong-path stores, then bump and store the marker x17
  function automatic void emit_branch(input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [4:0] rs2);
    emit(enc_b(13'd12, rs2, rs1, f3));
    emit(enc_sw(12'h1f0, 5'd17, 5'd0));
    emit(enc_sw(12'h1f4, 5'd17, 5'd0));
    emit(enc_i(12'd1, 5'd17, 3'b000, 5'd17, 7'b0010011));
    emit(enc_sw(12'h1e0, 5'd17, 5'd0));
  endfunction

  task automatic build_program();
    for (int i = 0; i < ROM_WORDS; i++)
      rom[i] = 32'h0000_0013;
    prog_len = 0;
    // Dependent ALU chain
    emit(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'd1, 7'b0010011));
    emit(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'd2, 7'b0010011));
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
    emit(enc_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
    emit(enc_r(7'h00, 5'd3, 5'd4, 3'b111, 5'd5));
    emit(enc_r(7'h00, 5'd2, 5'd5, 3'b110, 5'd6));
    emit(enc_r(7'h00, 5'd4, 5'd6, 3'b100, 5'd7));
    emit(enc_r(7'h00, 5'd1, 5'd7, 3'b001, 5'd8));
    emit(enc_i(12'(rand_bits(12)), 5'd8, 3'b111, 5'd9, 7'b0010011));
    emit(enc_i(12'(rand_bits(12)), 5'd9, 3'b110, 5'd10, 7'b0010011));
    emit(enc_i(12'(rand_bits(12)), 5'd10, 3'b100, 5'd11, 7'b0010011));
    emit(enc_i({7'd0, 5'(rand_bits(5))}, 5'd11, 3'b001, 5'd12, 7'b0010011));
    emit(enc_sw(12'h13c, 5'd12, 5'd0));
    for (int r = 3; r < 12; r++)
      emit(enc_sw(12'h100 + 12'(r * 4), 5'(r), 5'd0));
    // Load then immediate use
    emit(enc_i(12'h180, 5'd0, 3'b010, 5'd13, 7'b0000011));
    emit(enc_r(7'h00, 5'd1, 5'd13, 3'b000, 5'd14));
    emit(enc_sw(12'h140, 5'd14, 5'd0));
    // Branches
    emit(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'd15, 7'b0010011));
    emit(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'd16, 7'b0010011));
    emit_branch(3'b000, 5'd15, 5'd15);
    emit_branch(3'b000, 5'd15, 5'd16);
    emit_branch(3'b001, 5'd15, 5'd16);
    emit_branch(3'b001, 5'd16, 5'd16);
    emit_branch(3'b100, 5'd15, 5'd16);
    emit_branch(3'b100, 5'd16, 5'd15);
    emit_branch(3'b111, 5'd15, 5'd16);
    emit_branch(3'b111, 5'd16, 5'd15);
    // jal over two stores, then jalr through x21 over three
    emit(enc_jal(21'd12, 5'd18));
    emit(enc_sw(12'h1f0, 5'd18, 5'd0));
    emit(enc_sw(12'h1f4, 5'd18, 5'd0));
    emit(enc_sw(LINK_ADDR[11:0], 5'd18, 5'd0));
    jalr_target = RESET_PC + word_t'((prog_len + 5) * 4);
    emit(enc_i(jalr_target[11:0], 5'd0, 3'b000, 5'd21, 7'b0010011));
    emit(enc_i(12'd0, 5'd21, 3'b000, 5'd19, 7'b1100111));
    emit(enc_sw(12'h1f0, 5'd19, 5'd0));
    emit(enc_sw(12'h1f4, 5'd19, 5'd0));
    emit(enc_sw(12'h1f8, 5'd19, 5'd0));
    emit(enc_sw(12'h1c4, 5'd19, 5'd0));
    // lui and a write to x0
    emit({20'(rand_bits(20)), 5'd22, 7'b0110111});
    emit(enc_sw(12'h1c8, 5'd22, 5'd0));
    emit(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'd0, 7'b0010011));
    emit(enc_sw(12'h1cc, 5'd0, 5'd0));
    emit(enc_sw(DONE_ADDR[11:0], 5'd0, 5'd0));
    emit(enc_jal(21'd0, 5'd0));  // Park here
  endtask

  // Architectural model of the ROM program; fills the expected store lists
  function automatic void run_reference();
    word_t regs [0:31];
    word_t mem [0:511];
    word_t pc;
    word_t w;
    word_t a;
    word_t b;
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_j;
    word_t res;
    logic  done;
    for (int i = 0; i < 32; i++)
      regs[i] = '0;
    for (int i = 0; i < 512; i++)
      mem[i] = fill_word(i);
    pc = RESET_PC;
    done = 1'b0;
    for (int step = 0; step < 1000 && !done; step++)
    begin
      w = fetch(pc);
      a = regs[w[19:15]];
      b = regs[w[24:20]];
      imm_i = {{20{w[31]}}, w[31:20]};
      imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
      imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      res = '0;
      case (w[6:0])
        7'b0110011:
          case ({w[31:25], w[14:12]})
            10'h100: res = a - b;
            10'h007: res = a & b;
            10'h006: res = a | b;
            10'h004: res = a ^ b;
            10'h001: res = a << b[4:0];
            default: res = a + b;
          endcase
        7'b0010011:
          case (w[14:12])
            3'b111:  res = a & imm_i;
            3'b110:  res = a | imm_i;
            3'b100:  res = a ^ imm_i;
            3'b001:  res = a << imm_i[4:0];
            default: res = a + imm_i;
          endcase
        7'b0000011: res = mem[(a + imm_i) >> 2 & 32'h1ff];
        7'b0100011:
        begin
          exp_addr.push_back(a + imm_s);
          exp_data.push_back(b);
          mem[(a + imm_s) >> 2 & 32'h1ff] = b;
          done = ((a + imm_s) == DONE_ADDR);
        end
        7'b0110111: res = {w[31:12], 12'b0};
        7'b1101111: res = pc + 4;
        7'b1100111: res = pc + 4;
        default: ;
      endcase
      if (w[6:0] != 7'b0100011 && w[6:0] != 7'b1100011 && w[11:7] != 5'd0)
        regs[w[11:7]] = res;
      if (w[6:0] == 7'b1101111)
        pc = pc + imm_j;
      else if (w[6:0] == 7'b1100111)
        pc = (a + imm_i) & ~32'd1;
      else if (w[6:0] == 7'b1100011 &&
               ((w[14:12] == 3'b000 && a == b) || (w[14:12] == 3'b001 && a != b) ||
                (w[14:12] == 3'b100 && $signed(a) < $signed(b)) ||
                (w[14:12] == 3'b111 && a >= b)))
        pc = pc + imm_b;
      else
        pc = pc + 4;
    end
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_addr(input word_t got, input word_t exp);
    if (got !== exp)
      stop_with_failure($sformatf("Fail at %0t: store address %h, expected %h",
                                  $time, got, exp));
  endtask

  task automatic check_data(input word_t got, input word_t exp, input word_t addr);
    if (got !== exp)
      stop_with_failure($sformatf("Fail at %0t: store data %h at %h, expected %h",
                                  $time, got, addr, exp));
  endtask

  task automatic check_pc(input word_t got, input word_t exp);
    if (got !== exp)
      stop_with_failure($sformatf("Fail at %0t: pc %h, expected %h", $time, got, exp));
  endtask

  task automatic wait_store();
    int cnt;
    cnt = 0;
    do
    begin
      @(negedge clk);
      cnt++;
    end
    while (!o_mem_write && cnt < TIMEOUT);
    if (!o_mem_write)
      stop_with_failure("No store arrived from the core before the timeout");
  endtask

  // Follow o_pc until it leaves the sequential path, then check where it landed
  task automatic wait_for_jump(input word_t target);
    int    cnt;
    word_t prev;
    logic  jumped;
    cnt = 0;
    jumped = 1'b0;
    prev = o_pc;
    while (!jumped && cnt < TIMEOUT)
    begin
      @(negedge clk);
      cnt++;
      jumped = (o_pc !== prev) && (o_pc !== prev + 32'd4);
      prev = o_pc;
    end
    if (!jumped)
      stop_with_failure("The pc never left the sequential path before the timeout");
    check_pc(o_pc, target);
  endtask

  initial
  begin
    logic done_seen;
    lfsr_state = 32'hdf59;
    done_seen = 1'b0;
    for (int i = 0; i < 512; i++)
      dmem[i] = fill_word(i);
    build_program();
    run_reference();
    reset = 1'b1;
    repeat (16)
    begin
      @(negedge clk);
      if (o_mem_write)
        stop_with_failure("Store strobe was high during reset");
    end
    check_pc(o_pc, RESET_PC);
    reset = 1'b0;
    while (!done_seen && exp_addr.size() > 0)
    begin
      wait_store();
      check_addr(o_mem_addr, exp_addr[0]);
      check_data(o_mem_wdata, exp_data[0], o_mem_addr);
      void'(exp_addr.pop_front());
      void'(exp_data.pop_front());
      done_seen = (o_mem_addr == DONE_ADDR);
      if (o_mem_addr == LINK_ADDR)
        wait_for_jump(jalr_target);  // jalr follows the link store
    end
    if (done_seen && exp_addr.size() == 0)
    begin
      $display("STATUS: PASS");
      $finish;
    end
    else
      stop_with_failure("Run ended with expected stores still missing");
  end

endmodule

`default_nettype wire

//--- files.f
hdl/rv32i_isa_pkg.sv
hdl/pipe_pkg.sv
hdl/control_decoder.sv
hdl/regfile.sv
hdl/alu.sv
hdl/hazard_unit.sv
hdl/rv32i_cpu.sv
verif/tb_rv32i_cpu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv32i_cpu
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "STATUS: FAIL" $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
